// File: bakraid_pkg.sv
`default_nettype none

package bakraid_pkg;

    typedef logic [15:0] data_t;
    typedef logic [22:0] word_addr_t;   // byte address bits 23..1
    typedef logic [1:0]  byte_en_t;     // [1] upper byte, [0] lower byte
    typedef logic [7:0]  io_offset_t;
    typedef logic [7:0]  latch_t;
    typedef logic [5:0]  gcu_op_t;      // one-hot

    // strobe bit positions inside gcu_op_t
    localparam int GCU_WRITE_REG   = 0;
    localparam int GCU_SELECT_REG  = 1;
    localparam int GCU_WRITE_RAM   = 2;
    localparam int GCU_READ_RAM_H  = 3;
    localparam int GCU_READ_RAM_L  = 4;
    localparam int GCU_SET_RAM_PTR = 5;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_WRAM,
        REGION_GCU,
        REGION_IO
    } region_t;

    // byte address map
    localparam logic [23:0] WRAM_BASE      = 24'h208000;
    localparam int          WRAM_MASK_BITS = 15;       // 32 KB window
    localparam logic [23:0] GCU_BASE       = 24'h400000;
    localparam logic [23:0] IO_BASE        = 24'h500000;

    localparam io_offset_t IO_INPUTS     = 8'h00;
    localparam io_offset_t IO_DIPSW      = 8'h04;
    localparam io_offset_t IO_VSTATUS    = 8'h06;
    localparam io_offset_t IO_SND_REPLY0 = 8'h10;
    localparam io_offset_t IO_SND_REPLY1 = 8'h12;
    localparam io_offset_t IO_SND_CMD0   = 8'h14;
    localparam io_offset_t IO_SND_CMD1   = 8'h16;

endpackage

`default_nettype wire

// File: work_ram.sv
`timescale 1ns/1ps
`default_nettype none

module work_ram #(
    parameter int AW = 14
) (
    input  logic                   CLK96,
    input  logic                   wr_en,
    input  bakraid_pkg::byte_en_t  be,
    input  logic [AW-1:0]          addr,
    input  bakraid_pkg::data_t     wdata,
    output bakraid_pkg::data_t     rdata
);

    logic [7:0] mem_hi [2**AW];   // upper byte lane
    logic [7:0] mem_lo [2**AW];   // lower byte lane

    always_ff @(posedge CLK96) begin
        if (wr_en && be[1])
            mem_hi[addr] <= wdata[15:8];
        if (wr_en && be[0])
            mem_lo[addr] <= wdata[7:0];
        rdata <= {mem_hi[addr], mem_lo[addr]};   // old data on a same-cycle write
    end

endmodule

`default_nettype wire

// File: io_ports.sv
`timescale 1ns/1ps
`default_nettype none

module io_ports (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     access,
    input  logic                     write,
    input  bakraid_pkg::byte_en_t    be,
    input  bakraid_pkg::io_offset_t  offset,
    input  bakraid_pkg::data_t       wdata,
    output bakraid_pkg::data_t       rdata,
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  bakraid_pkg::latch_t      dipsw_a,
    input  bakraid_pkg::latch_t      dipsw_b,
    input  logic [8:0]               v_count,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  bakraid_pkg::latch_t      sound_reply0,
    input  bakraid_pkg::latch_t      sound_reply1,
    output bakraid_pkg::latch_t      sound_cmd0,
    output bakraid_pkg::latch_t      sound_cmd1,
    output logic                     nmi
);

    bakraid_pkg::data_t rd_mux;
    logic               cmd_wr;

    // joystick is active low, the game wants active high
    function automatic logic [7:0] player_byte(input logic [9:0] joy);
        return {1'b0, ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    always_comb begin
        case (offset)
            bakraid_pkg::IO_INPUTS:     rd_mux = {player_byte(joystick2), player_byte(joystick1)};
            bakraid_pkg::IO_DIPSW:      rd_mux = {dipsw_b, dipsw_a};
            bakraid_pkg::IO_VSTATUS:
                rd_mux = {hsync, vsync, 5'b11111, fblank, v_count[8] ? 8'hff : v_count[7:0]};
            bakraid_pkg::IO_SND_REPLY0: rd_mux = {8'h00, sound_reply0};
            bakraid_pkg::IO_SND_REPLY1: rd_mux = {8'h00, sound_reply1};
            default:                    rd_mux = '0;
        endcase
    end

    assign cmd_wr = access && write && be[0] &&
                    (offset == bakraid_pkg::IO_SND_CMD0 || offset == bakraid_pkg::IO_SND_CMD1);

    always_ff @(posedge CLK96) begin
        if (access && !write)
            rdata <= rd_mux;   // held until the next I/O read
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sound_cmd0 <= '0;
            sound_cmd1 <= '0;
            nmi        <= 1'b0;
        end else begin
            nmi <= cmd_wr;   // single cycle per command
            if (cmd_wr && offset == bakraid_pkg::IO_SND_CMD0)
                sound_cmd0 <= wdata[7:0];
            if (cmd_wr && offset == bakraid_pkg::IO_SND_CMD1)
                sound_cmd1 <= wdata[7:0];
        end
    end

endmodule

`default_nettype wire

// File: gcu_ops.sv
`timescale 1ns/1ps
`default_nettype none

module gcu_ops (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  start,
    input  logic                  write,
    input  logic [3:0]            offset,
    output bakraid_pkg::gcu_op_t  gcu_op,
    output logic [3:0]            gcu_op_addr,
    input  logic                  gcu_ack,
    input  bakraid_pkg::data_t    gcu_rdata,
    output logic                  done,
    output bakraid_pkg::data_t    rdata
);

    typedef enum logic {IDLE, WAIT_ACK} state_t;

    state_t               state;
    bakraid_pkg::gcu_op_t op_sel;
    logic                 is_read;

    always_comb begin
        op_sel = '0;
        if (write) begin
            case (offset)
                4'h0:       op_sel[bakraid_pkg::GCU_WRITE_REG]   = 1'b1;
                4'h4:       op_sel[bakraid_pkg::GCU_SELECT_REG]  = 1'b1;
                4'h8, 4'ha: op_sel[bakraid_pkg::GCU_WRITE_RAM]   = 1'b1;
                4'hc:       op_sel[bakraid_pkg::GCU_SET_RAM_PTR] = 1'b1;
                default:    op_sel = '0;
            endcase
        end else begin
            case (offset)
                4'h8:    op_sel[bakraid_pkg::GCU_READ_RAM_H] = 1'b1;
                4'ha:    op_sel[bakraid_pkg::GCU_READ_RAM_L] = 1'b1;
                default: op_sel = '0;
            endcase
        end
    end

    // no strobe for this offset -> finish right away
    assign done = (state == WAIT_ACK && gcu_ack) || (start && op_sel == '0);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state       <= IDLE;
            gcu_op      <= '0;
            gcu_op_addr <= '0;
            is_read     <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start && op_sel != '0) begin
                    gcu_op      <= op_sel;
                    gcu_op_addr <= offset;
                    is_read     <= !write;
                    state       <= WAIT_ACK;
                end
                WAIT_ACK: if (gcu_ack) begin
                    gcu_op <= '0;   // drop strobe on the ack edge
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (done)
            rdata <= (state == WAIT_ACK && is_read) ? gcu_rdata : '0;
    end

endmodule

`default_nettype wire

// File: bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  bakraid_pkg::word_addr_t  req_addr,
    input  bakraid_pkg::data_t       req_wdata,
    input  logic                     req_write,
    input  bakraid_pkg::byte_en_t    req_be,
    output logic                     dec_valid,
    input  logic                     dec_ready,
    output bakraid_pkg::region_t     dec_region,
    output bakraid_pkg::io_offset_t  dec_offset,
    output bakraid_pkg::word_addr_t  dec_addr,
    output bakraid_pkg::data_t       dec_wdata,
    output logic                     dec_write,
    output bakraid_pkg::byte_en_t    dec_be
);

    logic                 armed;      // low during reset and the edge after it
    logic [23:0]          byte_addr;
    bakraid_pkg::region_t region_nx;

    assign byte_addr = {req_addr, 1'b0};
    assign req_ready = armed && (!dec_valid || dec_ready);   // empty, or item leaving

    // the map is only looked at here
    always_comb begin
        if (byte_addr[23:bakraid_pkg::WRAM_MASK_BITS] ==
            bakraid_pkg::WRAM_BASE[23:bakraid_pkg::WRAM_MASK_BITS])
            region_nx = bakraid_pkg::REGION_WRAM;
        else if (byte_addr[23:16] == bakraid_pkg::GCU_BASE[23:16])
            region_nx = bakraid_pkg::REGION_GCU;
        else if (byte_addr[23:16] == bakraid_pkg::IO_BASE[23:16])
            region_nx = bakraid_pkg::REGION_IO;
        else
            region_nx = bakraid_pkg::REGION_NONE;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            armed     <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (req_ready)
                dec_valid <= req_valid;
        end
    end

    always_ff @(posedge CLK96) begin
        if (req_valid && req_ready) begin
            dec_region <= region_nx;
            dec_offset <= byte_addr[7:0];
            dec_addr   <= req_addr;
            dec_wdata  <= req_wdata;
            dec_write  <= req_write;
            dec_be     <= req_be;
        end
    end

endmodule

`default_nettype wire

// File: bus_access.sv
`timescale 1ns/1ps
`default_nettype none

module bus_access #(
    parameter int WRAM_AW = 14
) (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     dec_valid,
    output logic                     dec_ready,
    input  bakraid_pkg::region_t     dec_region,
    input  bakraid_pkg::io_offset_t  dec_offset,
    input  bakraid_pkg::word_addr_t  dec_addr,
    input  bakraid_pkg::data_t       dec_wdata,
    input  logic                     dec_write,
    input  bakraid_pkg::byte_en_t    dec_be,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output bakraid_pkg::data_t       resp_rdata,
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  bakraid_pkg::latch_t      dipsw_a,
    input  bakraid_pkg::latch_t      dipsw_b,
    input  logic [8:0]               v_count,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  bakraid_pkg::latch_t      sound_reply0,
    input  bakraid_pkg::latch_t      sound_reply1,
    output bakraid_pkg::latch_t      sound_cmd0,
    output bakraid_pkg::latch_t      sound_cmd1,
    output logic                     nmi,
    output bakraid_pkg::gcu_op_t     gcu_op,
    output logic [3:0]               gcu_op_addr,
    input  logic                     gcu_ack,
    input  bakraid_pkg::data_t       gcu_rdata
);

    logic                 accept;
    logic                 gcu_start;
    logic                 gcu_wait;    // strobe out, no ack yet
    logic                 gcu_done;
    bakraid_pkg::region_t resp_region;
    logic                 resp_write;
    logic [WRAM_AW-1:0]   ram_addr;
    logic [WRAM_AW-1:0]   ram_addr_q;
    bakraid_pkg::data_t   ram_rdata;
    bakraid_pkg::data_t   io_rdata;
    bakraid_pkg::data_t   gcu_data;

    assign dec_ready = !gcu_wait && (!resp_valid || resp_ready);
    assign accept    = dec_valid && dec_ready;
    assign gcu_start = accept && (dec_region == bakraid_pkg::REGION_GCU);

    // keep the RAM on the held address so its read register stays put
    assign ram_addr = accept ? dec_addr[WRAM_AW-1:0] : ram_addr_q;

    work_ram #(.AW(WRAM_AW)) u_wram (
        .CLK96 (CLK96),
        .wr_en (accept && dec_write && (dec_region == bakraid_pkg::REGION_WRAM)),
        .be    (dec_be),
        .addr  (ram_addr),
        .wdata (dec_wdata),
        .rdata (ram_rdata)
    );

    io_ports u_io (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .access       (accept && (dec_region == bakraid_pkg::REGION_IO)),
        .write        (dec_write),
        .be           (dec_be),
        .offset       (dec_offset),
        .wdata        (dec_wdata),
        .rdata        (io_rdata),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .v_count      (v_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .sound_reply0 (sound_reply0),
        .sound_reply1 (sound_reply1),
        .sound_cmd0   (sound_cmd0),
        .sound_cmd1   (sound_cmd1),
        .nmi          (nmi)
    );

    gcu_ops u_gcu (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .start       (gcu_start),
        .write       (dec_write),
        .offset      (dec_offset[3:0]),
        .gcu_op      (gcu_op),
        .gcu_op_addr (gcu_op_addr),
        .gcu_ack     (gcu_ack),
        .gcu_rdata   (gcu_rdata),
        .done        (gcu_done),
        .rdata       (gcu_data)
    );

    // writes answer with zero
    always_comb begin
        resp_rdata = '0;
        if (!resp_write) begin
            case (resp_region)
                bakraid_pkg::REGION_WRAM: resp_rdata = ram_rdata;
                bakraid_pkg::REGION_IO:   resp_rdata = io_rdata;
                bakraid_pkg::REGION_GCU:  resp_rdata = gcu_data;
                default:                  resp_rdata = '0;   // unmapped
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            resp_valid <= 1'b0;
            gcu_wait   <= 1'b0;
        end else begin
            if (resp_valid && resp_ready)
                resp_valid <= 1'b0;
            if ((accept && !gcu_start) || gcu_done)
                resp_valid <= 1'b1;
            if (gcu_done)
                gcu_wait <= 1'b0;
            else if (gcu_start)
                gcu_wait <= 1'b1;
        end
    end

    always_ff @(posedge CLK96) begin
        if (accept) begin
            resp_region <= dec_region;
            resp_write  <= dec_write;
            ram_addr_q  <= dec_addr[WRAM_AW-1:0];
        end
    end

endmodule

`default_nettype wire

// File: bakraid_bus.sv
`timescale 1ns/1ps
`default_nettype none

module bakraid_bus #(
    parameter int WRAM_AW = 14
) (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  bakraid_pkg::word_addr_t  req_addr,
    input  bakraid_pkg::data_t       req_wdata,
    input  logic                     req_write,
    input  bakraid_pkg::byte_en_t    req_be,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output bakraid_pkg::data_t       resp_rdata,
    input  logic [9:0]               joystick1,   // active low
    input  logic [9:0]               joystick2,
    input  bakraid_pkg::latch_t      dipsw_a,
    input  bakraid_pkg::latch_t      dipsw_b,
    input  logic [8:0]               v_count,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  bakraid_pkg::latch_t      sound_reply0,
    input  bakraid_pkg::latch_t      sound_reply1,
    output bakraid_pkg::latch_t      sound_cmd0,
    output bakraid_pkg::latch_t      sound_cmd1,
    output logic                     nmi,
    output bakraid_pkg::gcu_op_t     gcu_op,
    output logic [3:0]               gcu_op_addr,
    input  logic                     gcu_ack,
    input  bakraid_pkg::data_t       gcu_rdata
);

    // stage 1 -> stage 2
    logic                    dec_valid;
    logic                    dec_ready;
    bakraid_pkg::region_t    dec_region;
    bakraid_pkg::io_offset_t dec_offset;
    bakraid_pkg::word_addr_t dec_addr;
    bakraid_pkg::data_t      dec_wdata;
    logic                    dec_write;
    bakraid_pkg::byte_en_t   dec_be;

    bus_decode u_decode (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_write  (req_write),
        .req_be     (req_be),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec_region (dec_region),
        .dec_offset (dec_offset),
        .dec_addr   (dec_addr),
        .dec_wdata  (dec_wdata),
        .dec_write  (dec_write),
        .dec_be     (dec_be)
    );

    bus_access #(.WRAM_AW(WRAM_AW)) u_access (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_region   (dec_region),
        .dec_offset   (dec_offset),
        .dec_addr     (dec_addr),
        .dec_wdata    (dec_wdata),
        .dec_write    (dec_write),
        .dec_be       (dec_be),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_rdata   (resp_rdata),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .v_count      (v_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .sound_reply0 (sound_reply0),
        .sound_reply1 (sound_reply1),
        .sound_cmd0   (sound_cmd0),
        .sound_cmd1   (sound_cmd1),
        .nmi          (nmi),
        .gcu_op       (gcu_op),
        .gcu_op_addr  (gcu_op_addr),
        .gcu_ack      (gcu_ack),
        .gcu_rdata    (gcu_rdata)
    );

endmodule

`default_nettype wire

// File: tb_bakraid_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bakraid_bus;

    localparam int NREQ    = 27;
    localparam int TIMEOUT = 200;   // cycles allowed per wait

    // board inputs that stay put during a pass
    localparam logic [9:0]  JOY1     = 10'h2a5;
    localparam logic [9:0]  JOY2     = 10'h15c;
    localparam logic [7:0]  DSW_A    = 8'h3c;
    localparam logic [7:0]  DSW_B    = 8'hc1;
    localparam logic [7:0]  REPLY0   = 8'h5a;
    localparam logic [7:0]  REPLY1   = 8'ha7;
    localparam logic [15:0] GCU_DATA = 16'hbeef;

    logic        CLK96;
    logic        RESET96;
    logic        req_valid;
    logic        req_ready;
    logic [22:0] req_addr;
    logic [15:0] req_wdata;
    logic        req_write;
    logic [1:0]  req_be;
    logic        resp_valid;
    logic        resp_ready;
    logic [15:0] resp_rdata;
    logic [8:0]  v_count;
    logic        hsync;
    logic        vsync;
    logic        fblank;
    logic [7:0]  sound_cmd0;
    logic [7:0]  sound_cmd1;
    logic        nmi;
    logic [5:0]  gcu_op;
    logic [3:0]  gcu_op_addr;
    logic        gcu_ack;

    // six words per request in file column order
    logic [23:0] stim [0:6*NREQ-1];
    logic [15:0] exp_q [$];
    logic [9:0]  strobe_q [$];   // {op_addr, op}
    logic [9:0]  exp_strobe;
    integer      seed = 32'hd59f;
    int          errors;
    int          checks;
    int          nmi_pulses;
    int          cmd_writes;
    logic [7:0]  last_cmd0;
    logic [7:0]  last_cmd1;
    logic        nmi_last;
    logic        bp_en;
    logic        ack_busy;
    int          ack_delay;

    bakraid_bus #(.WRAM_AW(14)) dut_i (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_write    (req_write),
        .req_be       (req_be),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_rdata   (resp_rdata),
        .joystick1    (JOY1),
        .joystick2    (JOY2),
        .dipsw_a      (DSW_A),
        .dipsw_b      (DSW_B),
        .v_count      (v_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .sound_reply0 (REPLY0),
        .sound_reply1 (REPLY1),
        .sound_cmd0   (sound_cmd0),
        .sound_cmd1   (sound_cmd1),
        .nmi          (nmi),
        .gcu_op       (gcu_op),
        .gcu_op_addr  (gcu_op_addr),
        .gcu_ack      (gcu_ack),
        .gcu_rdata    (GCU_DATA)
    );

    initial CLK96 = 1'b0;
    always #4 CLK96 = ~CLK96;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // active-low stick read as bits 6 5 4 0 1 2 3 from the top
    function automatic logic [7:0] player_bits(input logic [9:0] joy);
        logic [7:0] p;
        p    = 8'h00;
        p[6] = !joy[6];
        p[5] = !joy[5];
        p[4] = !joy[4];
        p[3] = !joy[0];
        p[2] = !joy[1];
        p[1] = !joy[2];
        p[0] = !joy[3];
        return p;
    endfunction

    function automatic logic [15:0] io_expect(input logic [7:0] off);
        logic [15:0] v;
        v = 16'h0000;
        case (off)
            8'h00: v = {player_bits(JOY2), player_bits(JOY1)};
            8'h04: v = {DSW_B, DSW_A};
            8'h06: begin
                v[15]   = hsync;
                v[14]   = vsync;
                v[13:9] = 5'h1f;
                v[8]    = fblank;
                v[7:0]  = (v_count < 9'd256) ? v_count[7:0] : 8'hff;
            end
            8'h10: v[7:0] = REPLY0;
            8'h12: v[7:0] = REPLY1;
            default: v = 16'h0000;
        endcase
        return v;
    endfunction

    function automatic logic [15:0] expect_for(input int k);
        logic [23:0] a;
        a = stim[6*k+1];
        if (stim[6*k][0])
            return 16'h0000;          // writes answer zero
        if (!stim[6*k+5][0])
            return stim[6*k+4][15:0];
        if (a[23:16] == 8'h50)
            return io_expect(a[7:0]);
        if (a[3:0] == 4'h8 || a[3:0] == 4'ha)
            return GCU_DATA;
        return 16'h0000;
    endfunction

    function automatic logic [5:0] strobe_for(input logic wr, input logic [3:0] off);
        logic [5:0] s;
        s = 6'b0;
        if (wr && off == 4'h0)
            s[bakraid_pkg::GCU_WRITE_REG] = 1'b1;
        else if (wr && off == 4'h4)
            s[bakraid_pkg::GCU_SELECT_REG] = 1'b1;
        else if (wr && (off == 4'h8 || off == 4'ha))
            s[bakraid_pkg::GCU_WRITE_RAM] = 1'b1;
        else if (wr && off == 4'hc)
            s[bakraid_pkg::GCU_SET_RAM_PTR] = 1'b1;
        else if (!wr && off == 4'h8)
            s[bakraid_pkg::GCU_READ_RAM_H] = 1'b1;
        else if (!wr && off == 4'ha)
            s[bakraid_pkg::GCU_READ_RAM_L] = 1'b1;
        return s;
    endfunction

    task automatic send(input int k);
        logic [23:0] a;
        logic [5:0]  op;
        int          waited;
        a  = stim[6*k+1];
        op = strobe_for(stim[6*k][0], a[3:0]);
        @(negedge CLK96);
        req_valid = 1'b1;
        req_addr  = a[23:1];
        req_wdata = stim[6*k+2][15:0];
        req_write = stim[6*k][0];
        req_be    = stim[6*k+3][1:0];
        waited    = 0;
        #1;
        while (!req_ready && waited < TIMEOUT) begin
            @(negedge CLK96);
            #1;
            waited++;
        end
        if (!req_ready) begin
            errors++;
            $display("timeout: request %0d was never accepted", k);
        end else begin
            exp_q.push_back(expect_for(k));
            if (a[23:16] == 8'h40 && op != 6'b0)
                strobe_q.push_back({a[3:0], op});
        end
        @(posedge CLK96);   // transfer edge
    endtask

    task automatic drive_all();
        int k;
        for (k = 0; k < NREQ; k++)
            send(k);
        @(negedge CLK96);
        req_valid = 1'b0;
    endtask

    task automatic collect_all();
        int          k;
        int          waited;
        logic        stuck;
        logic [15:0] exp;
        stuck = 1'b0;
        for (k = 0; k < NREQ && !stuck; k++) begin
            waited = 0;
            @(negedge CLK96);
            #1;
            while (!(resp_valid && resp_ready) && waited < TIMEOUT) begin
                @(negedge CLK96);
                #1;
                waited++;
            end
            if (!(resp_valid && resp_ready)) begin
                errors++;
                stuck = 1'b1;
                $display("timeout: no response came for request %0d", k);
            end else if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived with no request outstanding");
            end else begin
                exp = exp_q.pop_front();
                check("resp_rdata", resp_rdata, exp);
            end
        end
    endtask

    task automatic run_pass(input logic bp);
        @(posedge CLK96);
        bp_en      = bp;
        nmi_pulses = 0;
        fork
            drive_all();
            collect_all();
        join
        repeat (4) @(negedge CLK96);
        check("resp_valid", resp_valid, 0);   // no extra response
        check("nmi_pulses", nmi_pulses, cmd_writes);
        check("sound_cmd0", sound_cmd0, last_cmd0);
        check("sound_cmd1", sound_cmd1, last_cmd1);
        check("pending_strobes", strobe_q.size(), 0);   // every expected strobe was seen
    endtask

    // sound and video controller side with response back-pressure
    always @(negedge CLK96) begin
        resp_ready = bp_en ? ({$random(seed)} % 3 != 0) : 1'b1;
        if (nmi && nmi_last) begin
            errors++;
            $display("nmi stayed high for more than one cycle at %0t", $time);
        end
        if (nmi && !nmi_last)
            nmi_pulses++;
        nmi_last = nmi;
        if (gcu_ack) begin
            gcu_ack = 1'b0;
            check("gcu_op", gcu_op, 0);   // strobe gone after the ack edge
        end else if (gcu_op != 6'b0) begin
            if (!ack_busy) begin
                if (strobe_q.size() == 0) begin
                    errors++;
                    $display("a video strobe was raised with no matching request");
                end else begin
                    exp_strobe = strobe_q.pop_front();
                    check("gcu_op", gcu_op, exp_strobe[5:0]);
                    check("gcu_op_addr", gcu_op_addr, exp_strobe[9:6]);
                end
                ack_delay = {$random(seed)} % 6;
                ack_busy  = 1'b1;
            end else begin
                check("gcu_op", gcu_op, exp_strobe[5:0]);   // still held
            end
            if (ack_delay == 0) begin
                gcu_ack  = 1'b1;
                ack_busy = 1'b0;
            end else begin
                ack_delay--;
            end
        end else if (ack_busy) begin
            errors++;
            ack_busy = 1'b0;
            $display("a video strobe dropped before its acknowledge");
        end
    end

    initial begin : main
        int          k;
        logic [23:0] a;
        RESET96    = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_write  = 1'b0;
        req_be     = 2'b00;
        resp_ready = 1'b1;
        gcu_ack    = 1'b0;
        v_count    = 9'h0f0;
        hsync      = 1'b1;
        vsync      = 1'b0;
        fblank     = 1'b1;
        bp_en      = 1'b0;
        ack_busy   = 1'b0;
        ack_delay  = 0;
        nmi_last   = 1'b0;
        nmi_pulses = 0;
        errors     = 0;
        checks     = 0;
        cmd_writes = 0;
        last_cmd0  = 8'h00;
        last_cmd1  = 8'h00;
        $readmemh("bakraid_stim.txt", stim);
        if ($isunknown(stim[6*NREQ-1])) begin
            errors++;
            $display("the stimulus file is missing or too short");
        end
        // sound commands the list should leave behind
        for (k = 0; k < NREQ; k++) begin
            a = stim[6*k+1];
            if (stim[6*k][0] && a[23:16] == 8'h50 && stim[6*k+3][0]) begin
                if (a[7:0] == 8'h14) begin
                    cmd_writes++;
                    last_cmd0 = stim[6*k+2][7:0];
                end
                if (a[7:0] == 8'h16) begin
                    cmd_writes++;
                    last_cmd1 = stim[6*k+2][7:0];
                end
            end
        end
        repeat (8) @(negedge CLK96);
        check("req_ready", req_ready, 0);
        check("resp_valid", resp_valid, 0);
        check("nmi", nmi, 0);
        check("gcu_op", gcu_op, 0);
        check("sound_cmd0", sound_cmd0, 0);
        check("sound_cmd1", sound_cmd1, 0);
        RESET96 = 1'b0;
        run_pass(1'b0);
        v_count = 9'h120;   // vstatus low byte saturates now
        run_pass(1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: bakraid_stim.txt
// columns: write  byte_addr  wdata  be  expected_rdata  rule_flag
// rule_flag 1 means the expected data comes from the I/O and video rules
1 208000 1234 3 0000 0
1 208002 abcd 3 0000 0
1 208000 ff99 2 0000 0
1 208002 0077 1 0000 0
0 208000 0000 3 ff34 0
0 208002 0000 3 ab77 0
1 20fffe 5aa5 3 0000 0
0 20fffe 0000 3 5aa5 0
0 200000 0000 3 0000 0
1 300000 ffff 3 0000 0
0 500000 0000 3 0000 1
0 500004 0000 3 0000 1
0 500006 0000 3 0000 1
0 500010 0000 3 0000 1
0 500012 0000 3 0000 1
1 500014 0042 1 0000 0
0 500008 0000 3 0000 1
1 500016 0099 1 0000 0
1 500014 0011 2 0000 0
1 400000 1111 3 0000 0
1 400004 2222 3 0000 0
1 400008 3333 3 0000 0
1 40000a 4444 3 0000 0
1 40000c 5555 3 0000 0
0 400008 0000 3 0000 1
0 40000a 0000 3 0000 1
0 400002 0000 3 0000 1

// File: bakraid_bus.f
bakraid_pkg.sv
work_ram.sv
io_ports.sv
gcu_ops.sv
bus_decode.sv
bus_access.sv
bakraid_bus.sv
tb_bakraid_bus.sv

// File: Bender.yml
package:
  name: bakraid_bus

sources:
  - bakraid_pkg.sv
  - work_ram.sv
  - io_ports.sv
  - gcu_ops.sv
  - bus_decode.sv
  - bus_access.sv
  - bakraid_bus.sv
  - target: test
    files:
      - tb_bakraid_bus.sv
